//--- sim.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_commit_if.sv
verilog/csr_timer_if.sv
verilog/csr_ctrl.sv
verilog/csr_regfile.sv
verilog/csr_timer.sv
verilog/csr_unit.sv
sim/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/csr_pkg.sv
      - verilog/csr_commit_if.sv
      - verilog/csr_timer_if.sv
      - verilog/csr_ctrl.sv
      - verilog/csr_regfile.sv
      - verilog/csr_timer.sv
      - verilog/csr_unit.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/csr_unit_tb.sv

//--- sim/csr_unit_tb.sv
`timescale 1ns/100ps
`include "csr_config.svh"

module csr_unit_tb;

    localparam int N_RAND   = 2000;
    localparam int N_CYCLES = 10 + 64 + N_RAND;    // reset, directed bound, random

    logic                clk;
    logic                rstn;
    logic                cmd_valid;
    csr_pkg::csr_op_t    cmd_op;
    csr_pkg::csr_num_t   cmd_csr_num;
    csr_pkg::csr_data_t  cmd_wdata;
    csr_pkg::csr_data_t  cmd_mask;
    csr_pkg::csr_data_t  cmd_pc;
    csr_pkg::ecode_t     cmd_ecode;
    csr_pkg::esubcode_t  cmd_esubcode;
    csr_pkg::csr_data_t  cmd_badv;
    csr_pkg::hwi_t       hw_int;
    logic                ipi;
    csr_pkg::csr_data_t  rdata;
    logic                redirect;
    csr_pkg::csr_data_t  redirect_pc;
    csr_pkg::crmd_t      crmd;

    // reference model state
    csr_pkg::crmd_t      m_crmd;
    logic [2:0]          m_prmd;
    csr_pkg::int_vec_t   m_ecfg;
    logic [1:0]          m_is;
    csr_pkg::ecode_t     m_ecode;
    csr_pkg::esubcode_t  m_esub;
    csr_pkg::csr_data_t  m_era;
    csr_pkg::csr_data_t  m_badv;
    csr_pkg::csr_data_t  m_eentry;
    csr_pkg::csr_data_t  m_save [4];
    csr_pkg::csr_data_t  m_tid;
    csr_pkg::csr_data_t  m_tcfg;
    csr_pkg::csr_data_t  m_tval;
    logic                m_ti;
    logic                m_load;         // tval load due at next edge
    csr_pkg::csr_data_t  m_rdata;
    logic                m_redirect;
    csr_pkg::csr_data_t  m_redirect_pc;

    logic [31:0]         rng;
    int                  errors;
    int                  checks;

    csr_unit csr_unit_i (
        .clk          (clk),
        .rstn         (rstn),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_csr_num  (cmd_csr_num),
        .cmd_wdata    (cmd_wdata),
        .cmd_mask     (cmd_mask),
        .cmd_pc       (cmd_pc),
        .cmd_ecode    (cmd_ecode),
        .cmd_esubcode (cmd_esubcode),
        .cmd_badv     (cmd_badv),
        .hw_int       (hw_int),
        .ipi          (ipi),
        .rdata        (rdata),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .crmd         (crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        #(2 * N_CYCLES * 100);
        $display("watchdog expired at %0t, the test did not complete", $time);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic csr_pkg::csr_num_t pick_csr(input logic [3:0] idx);
        case (idx)
            4'd0:    return `CSR_ADDR_CRMD;
            4'd1:    return `CSR_ADDR_PRMD;
            4'd2:    return 14'h2;          // not implemented
            4'd3:    return `CSR_ADDR_ECFG;
            4'd4:    return `CSR_ADDR_ESTAT;
            4'd5:    return `CSR_ADDR_ERA;
            4'd6:    return `CSR_ADDR_BADV;
            4'd7:    return `CSR_ADDR_EENTRY;
            4'd8:    return `CSR_ADDR_SAVE0;
            4'd9:    return `CSR_ADDR_SAVE1;
            4'd10:   return `CSR_ADDR_SAVE2;
            4'd11:   return `CSR_ADDR_SAVE3;
            4'd12:   return `CSR_ADDR_TID;
            4'd13:   return `CSR_ADDR_TCFG;
            4'd14:   return `CSR_ADDR_TVAL;
            default: return `CSR_ADDR_TICLR;
        endcase
    endfunction

    function automatic csr_pkg::csr_data_t expected_csr(input csr_pkg::csr_num_t num);
        csr_pkg::csr_data_t v;
        v = '0;
        case (num)
            `CSR_ADDR_CRMD:   v[8:0] = m_crmd;
            `CSR_ADDR_PRMD:   v[2:0] = m_prmd;
            `CSR_ADDR_ECFG:   v[12:0] = m_ecfg;
            `CSR_ADDR_ESTAT:  v = {1'b0, m_esub, m_ecode, 3'b000, ipi, m_ti, 1'b0, hw_int, m_is};
            `CSR_ADDR_ERA:    v = m_era;
            `CSR_ADDR_BADV:   v = m_badv;
            `CSR_ADDR_EENTRY: v = m_eentry;
            `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1, `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3:
                v = m_save[num[1:0]];
            `CSR_ADDR_TID:    v = m_tid;
            `CSR_ADDR_TCFG:   v = m_tcfg;
            `CSR_ADDR_TVAL:   v = m_tval;
            default:          v = '0;
        endcase
        return v;
    endfunction

    function automatic void store_csr(input csr_pkg::csr_num_t num, input csr_pkg::csr_data_t v);
        case (num)
            `CSR_ADDR_CRMD:
            begin
                m_crmd[2:0] = v[2:0];
                m_crmd[8:5] = v[8:5];
                if (v[`CRMD_DA] != v[`CRMD_PG])
                    m_crmd[4:3] = v[4:3];
            end
            `CSR_ADDR_PRMD:   m_prmd = v[2:0];
            `CSR_ADDR_ECFG:   m_ecfg = v[12:0] & 13'h1bff;     // bit 10 reserved
            `CSR_ADDR_ESTAT:  m_is = v[1:0];
            `CSR_ADDR_ERA:    m_era = v;
            `CSR_ADDR_BADV:   m_badv = v;
            `CSR_ADDR_EENTRY: m_eentry = {v[31:6], 6'b0};
            `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1, `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3:
                m_save[num[1:0]] = v;
            `CSR_ADDR_TID:    m_tid = v;
            `CSR_ADDR_TCFG:   m_tcfg = v;
            default:          m_tid = m_tid;
        endcase
    endfunction

    function automatic void enter_exception(input csr_pkg::ecode_t code,
                                            input csr_pkg::esubcode_t sub, input logic badv_we);
        m_prmd      = m_crmd[2:0];
        m_crmd[2:0] = 3'b000;
        m_era       = cmd_pc;
        m_ecode     = code;
        m_esub      = sub;
        if (badv_we)
            m_badv = cmd_badv;
    endfunction

    // next model state from the inputs in front of the coming edge
    function automatic void predict_edge();
        csr_pkg::csr_data_t old_val;
        csr_pkg::csr_data_t mask;
        csr_pkg::csr_data_t merged;
        csr_pkg::csr_data_t init_val;
        csr_pkg::csr_data_t tval_next;
        csr_pkg::int_vec_t  ints;
        logic               take_int;
        logic               wr_en;
        logic               running;
        logic               ti_next;
        logic               load_next;

        old_val  = expected_csr(cmd_csr_num);
        ints     = {ipi, m_ti, 1'b0, hw_int, m_is};
        take_int = m_crmd[`CRMD_IE] && (ints & m_ecfg) != '0;
        wr_en    = cmd_valid && !take_int &&
                   (cmd_op == csr_pkg::OP_CSRWR || cmd_op == csr_pkg::OP_CSRXCHG);
        mask     = (cmd_op == csr_pkg::OP_CSRWR) ? '1 : cmd_mask;
        merged   = (old_val & ~mask) | (cmd_wdata & mask);

        running   = m_tcfg[`TCFG_EN] && !m_load;
        init_val  = {m_tcfg[31:2], 2'b00};
        tval_next = m_tval;
        if (m_load)
            tval_next = init_val;
        else if (running && m_tval == '0)
            tval_next = m_tcfg[`TCFG_PERIODIC] ? init_val : '1;
        else if (running && (m_tcfg[`TCFG_PERIODIC] || m_tval != '1))
            tval_next = m_tval - 1;
        ti_next = m_ti;
        if (wr_en && cmd_csr_num == `CSR_ADDR_TICLR && merged[0])
            ti_next = 1'b0;
        else if (running && m_tval == '0)
            ti_next = 1'b1;
        load_next = wr_en && cmd_csr_num == `CSR_ADDR_TCFG && merged[`TCFG_EN];

        m_redirect = 1'b0;
        if (take_int)
        begin
            m_redirect    = 1'b1;
            m_redirect_pc = m_eentry;
            enter_exception(`ECODE_INT, '0, 1'b0);
        end
        else if (cmd_valid)
        begin
            case (cmd_op)
                csr_pkg::OP_CSRRD:
                    m_rdata = old_val;
                csr_pkg::OP_CSRWR, csr_pkg::OP_CSRXCHG:
                begin
                    m_rdata       = old_val;
                    m_redirect    = 1'b1;
                    m_redirect_pc = cmd_pc + `CSR_PC_STEP;
                    store_csr(cmd_csr_num, merged);
                end
                csr_pkg::OP_ERTN:
                begin
                    m_redirect    = 1'b1;
                    m_redirect_pc = m_era;
                    m_crmd[2:0]   = m_prmd;
                end
                default:
                begin
                    m_redirect    = 1'b1;
                    m_redirect_pc = m_eentry;
                    enter_exception(cmd_ecode, cmd_esubcode,
                                    cmd_ecode == `ECODE_ADE || cmd_ecode == `ECODE_ALE);
                end
            endcase
        end
        m_tval = tval_next;
        m_ti   = ti_next;
        m_load = load_next;
    endfunction

    task automatic compare_outputs();
        checks++;
        if (redirect !== m_redirect)
        begin
            $display("FAIL t=%0t redirect expected %b got %b", $time, m_redirect, redirect);
            errors++;
        end
        else if (m_redirect && redirect_pc !== m_redirect_pc)
        begin
            $display("FAIL t=%0t redirect_pc expected %h got %h", $time, m_redirect_pc,
                     redirect_pc);
            errors++;
        end
        if (rdata !== m_rdata)
        begin
            $display("FAIL t=%0t rdata expected %h got %h", $time, m_rdata, rdata);
            errors++;
        end
        if (crmd !== m_crmd)
        begin
            $display("FAIL t=%0t crmd expected %h got %h", $time, m_crmd, crmd);
            errors++;
        end
    endtask

    task automatic run_cycle();
        predict_edge();
        @(posedge clk);
        #1;
        compare_outputs();
    endtask

    task automatic do_cmd(input csr_pkg::csr_op_t op, input csr_pkg::csr_num_t num,
                          input csr_pkg::csr_data_t wdata, input csr_pkg::csr_data_t mask);
        cmd_valid   = 1'b1;
        cmd_op      = op;
        cmd_csr_num = num;
        cmd_wdata   = wdata;
        cmd_mask    = mask;
        cmd_pc      = cmd_pc + 4;
        hw_int      = '0;
        ipi         = 1'b0;
        run_cycle();
    endtask

    task automatic random_cmd();
        logic [31:0] r;
        r = rand32();
        cmd_valid = r[3:0] != 4'h0;
        case (r[7:4])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: cmd_op = csr_pkg::OP_CSRRD;
            4'd6, 4'd7, 4'd8, 4'd9:             cmd_op = csr_pkg::OP_CSRWR;
            4'd10, 4'd11, 4'd12, 4'd13:         cmd_op = csr_pkg::OP_CSRXCHG;
            4'd14:                              cmd_op = csr_pkg::OP_ERTN;
            default:                            cmd_op = csr_pkg::OP_EXCP;
        endcase
        cmd_csr_num  = pick_csr(r[11:8]);
        cmd_mask     = r[12] ? '1 : rand32();
        cmd_ecode    = (r[14:13] == 2'd0) ? `ECODE_ADE :
                       (r[14:13] == 2'd1) ? `ECODE_ALE : r[20:15];
        cmd_esubcode = r[29:21];
        r = rand32();
        // short countdowns so the timer wraps often
        cmd_wdata = (cmd_csr_num == `CSR_ADDR_TCFG) ? {27'b0, r[4:0]} : r;
        r = rand32();
        cmd_pc   = {r[31:2], 2'b00};
        cmd_badv = rand32();
        r = rand32();
        hw_int = (r[2:0] == 3'd0) ? 8'h1 << r[5:3] : '0;
        ipi    = r[9:6] == 4'd0;
    endtask

    initial
    begin
        rng          = 32'd30;
        errors       = 0;
        checks       = 0;
        rstn         = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = csr_pkg::OP_CSRRD;
        cmd_csr_num  = '0;
        cmd_wdata    = '0;
        cmd_mask     = '0;
        cmd_pc       = 32'h1c00_0000;
        cmd_ecode    = '0;
        cmd_esubcode = '0;
        cmd_badv     = '0;
        hw_int       = '0;
        ipi          = 1'b0;

        m_crmd = 9'h8;
        m_prmd = '0;
        m_ecfg = '0;
        m_is = '0;
        m_ecode = '0;
        m_esub = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = '0;
        m_tid = '0;
        m_tcfg = '0;
        m_tval = '0;
        m_ti = 1'b0;
        m_load = 1'b0;
        m_rdata = '0;
        m_redirect = 1'b0;
        m_redirect_pc = '0;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;

        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        compare_outputs();

        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_EENTRY, 32'h1c00_0fff, '1);
        do_cmd(csr_pkg::OP_CSRXCHG, `CSR_ADDR_SAVE0, 32'hdead_beef, 32'hffff_0000);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_SAVE0, '0, '0);

        // periodic countdown from 8
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_TCFG, 32'h0000_000b, '1);
        repeat (20) do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_TVAL, '0, '0);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_ESTAT, '0, '0);
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_TICLR, 32'h1, '1);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_ESTAT, '0, '0);

        // one-shot, then frozen
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_TCFG, 32'h0000_0009, '1);
        repeat (14) do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_TVAL, '0, '0);
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_TCFG, 32'h0000_0009, '1);
        repeat (4) do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_TVAL, '0, '0);
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_TCFG, 32'h0000_0008, '1);     // stop mid count
        repeat (3) do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_TVAL, '0, '0);

        // timer interrupt with ie set
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_ECFG, 32'h0000_0800, '1);
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_CRMD, 32'h0000_000c, '1);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_ERA, '0, '0);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_ESTAT, '0, '0);
        do_cmd(csr_pkg::OP_ERTN, '0, '0, '0);
        do_cmd(csr_pkg::OP_CSRWR, `CSR_ADDR_TICLR, 32'h1, '1);

        cmd_ecode = `ECODE_ADE;
        cmd_badv  = 32'h0bad_0bad;
        do_cmd(csr_pkg::OP_EXCP, '0, '0, '0);
        cmd_ecode = 6'h3;
        do_cmd(csr_pkg::OP_EXCP, '0, '0, '0);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_BADV, '0, '0);
        do_cmd(csr_pkg::OP_CSRRD, `CSR_ADDR_PRMD, '0, '0);

        repeat (N_RAND)
        begin
            random_cmd();
            run_cycle();
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog/csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
    input  logic                clk,
    input  logic                rstn,
    input  logic                cmd_valid,
    input  csr_pkg::csr_op_t    cmd_op,
    input  csr_pkg::csr_num_t   cmd_csr_num,
    input  csr_pkg::csr_data_t  cmd_wdata,
    input  csr_pkg::csr_data_t  cmd_mask,
    input  csr_pkg::csr_data_t  cmd_pc,
    input  csr_pkg::ecode_t     cmd_ecode,
    input  csr_pkg::esubcode_t  cmd_esubcode,
    input  csr_pkg::csr_data_t  cmd_badv,
    input  csr_pkg::hwi_t       hw_int,
    input  logic                ipi,
    output csr_pkg::csr_data_t  rdata,
    output logic                redirect,
    output csr_pkg::csr_data_t  redirect_pc,
    output csr_pkg::crmd_t      crmd
);

    csr_commit_if commit_bus ();
    csr_timer_if  timer_bus ();

    csr_ctrl ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_csr_num  (cmd_csr_num),
        .cmd_wdata    (cmd_wdata),
        .cmd_mask     (cmd_mask),
        .cmd_pc       (cmd_pc),
        .cmd_ecode    (cmd_ecode),
        .cmd_esubcode (cmd_esubcode),
        .cmd_badv     (cmd_badv),
        .commit       (commit_bus.ctrl),
        .rdata        (rdata),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    csr_regfile regfile_i (
        .clk    (clk),
        .rstn   (rstn),
        .hw_int (hw_int),
        .ipi    (ipi),
        .commit (commit_bus.regfile),
        .timer  (timer_bus.regfile),
        .crmd   (crmd)
    );

    csr_timer timer_i (
        .clk   (clk),
        .rstn  (rstn),
        .timer (timer_bus.timer)
    );

endmodule

//--- verilog/csr_timer.sv
`timescale 1ns/100ps
`include "csr_config.svh"

module csr_timer (
    input  logic        clk,
    input  logic        rstn,
    csr_timer_if.timer  timer
);

    csr_pkg::csr_data_t tcfg_q;
    csr_pkg::csr_data_t tval_q;
    csr_pkg::csr_data_t init_val;
    logic               ti_q;
    logic               load_q;     // enable written at last edge
    logic               running;
    logic               hit_zero;
    logic               parked;     // one-shot done

    assign init_val = {tcfg_q[`TCFG_INITV_HI:`TCFG_INITV_LO], 2'b00};
    assign running  = tcfg_q[`TCFG_EN] && !load_q;
    assign hit_zero = running && tval_q == '0;
    assign parked   = tval_q == '1 && !tcfg_q[`TCFG_PERIODIC];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_q <= '0;
            tval_q <= '0;
            ti_q   <= 1'b0;
            load_q <= 1'b0;
        end
        else
        begin
            load_q <= timer.tcfg_we && timer.tcfg_wdata[`TCFG_EN];
            if (timer.tcfg_we)
                tcfg_q <= timer.tcfg_wdata;

            if (load_q)
                tval_q <= init_val;
            else if (hit_zero)
                tval_q <= tcfg_q[`TCFG_PERIODIC] ? init_val : '1;
            else if (running && !parked)
                tval_q <= tval_q - 1'b1;

            if (timer.ticlr)
                ti_q <= 1'b0;           // clear beats a new hit
            else if (hit_zero)
                ti_q <= 1'b1;
        end
    end

    assign timer.tcfg = tcfg_q;
    assign timer.tval = tval_q;
    assign timer.ti   = ti_q;

endmodule

//--- verilog/csr_regfile.sv
`timescale 1ns/100ps
`include "csr_config.svh"

module csr_regfile (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::hwi_t      hw_int,
    input  logic               ipi,
    csr_commit_if.regfile      commit,
    csr_timer_if.regfile       timer,
    output csr_pkg::crmd_t     crmd
);

    csr_pkg::crmd_t         crmd_q;
    logic [2:0]             prmd_q;         // pplv and pie
    csr_pkg::int_vec_t      ecfg_lie;
    logic [1:0]             estat_is;       // software interrupt bits
    csr_pkg::ecode_t        estat_ecode;
    csr_pkg::esubcode_t     estat_esubcode;
    csr_pkg::csr_data_t     era_q;
    csr_pkg::csr_data_t     badv_q;
    logic [`CSR_DATA_W-1:6] eentry_q;       // 64 byte aligned
    csr_pkg::csr_data_t     save_q [4];
    csr_pkg::csr_data_t     tid_q;
    csr_pkg::int_vec_t      int_vec;
    csr_pkg::csr_data_t     estat_val;

    assign int_vec   = {ipi, timer.ti, 1'b0, hw_int, estat_is};
    assign estat_val = {1'b0, estat_esubcode, estat_ecode, 3'b0, int_vec};

    assign commit.int_pending = crmd_q[`CRMD_IE] && |(int_vec & ecfg_lie);
    assign commit.era         = era_q;
    assign commit.eentry      = {eentry_q, 6'b0};
    assign crmd               = crmd_q;

    // timer side of the write decode
    assign timer.tcfg_we    = commit.we && commit.wnum == `CSR_ADDR_TCFG;
    assign timer.tcfg_wdata = commit.wdata;
    assign timer.ticlr      = commit.we && commit.wnum == `CSR_ADDR_TICLR && commit.wdata[0];

    always_comb
    begin
        commit.rdata = '0;
        case (commit.rnum)
            `CSR_ADDR_CRMD:   commit.rdata[8:0] = crmd_q;
            `CSR_ADDR_PRMD:   commit.rdata[2:0] = prmd_q;
            `CSR_ADDR_ECFG:   commit.rdata[12:0] = ecfg_lie;
            `CSR_ADDR_ESTAT:  commit.rdata = estat_val;
            `CSR_ADDR_ERA:    commit.rdata = era_q;
            `CSR_ADDR_BADV:   commit.rdata = badv_q;
            `CSR_ADDR_EENTRY: commit.rdata = {eentry_q, 6'b0};
            `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1, `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3:
                commit.rdata = save_q[commit.rnum[1:0]];
            `CSR_ADDR_TID:    commit.rdata = tid_q;
            `CSR_ADDR_TCFG:   commit.rdata = timer.tcfg;
            `CSR_ADDR_TVAL:   commit.rdata = timer.tval;
            default:          commit.rdata = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q         <= 9'h8;         // da set
            prmd_q         <= '0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_q          <= '0;
            badv_q         <= '0;
            eentry_q       <= '0;
            tid_q          <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
        end
        else if (commit.excp_enter)
        begin
            prmd_q                           <= crmd_q[`CRMD_IE:`CRMD_PLV_LO];
            crmd_q[`CRMD_IE:`CRMD_PLV_LO]    <= '0;     // plv0, ie off
            era_q                            <= commit.era_pc;
            estat_ecode                      <= commit.ecode;
            estat_esubcode                   <= commit.esubcode;
            if (commit.badv_we)
                badv_q <= commit.badv;
        end
        else if (commit.ertn)
            crmd_q[`CRMD_IE:`CRMD_PLV_LO] <= prmd_q;
        else if (commit.we)
        begin
            case (commit.wnum)
                `CSR_ADDR_CRMD:
                begin
                    crmd_q[`CRMD_PLV_HI:`CRMD_PLV_LO] <= commit.wdata[`CRMD_PLV_HI:`CRMD_PLV_LO];
                    crmd_q[`CRMD_IE]                  <= commit.wdata[`CRMD_IE];
                    crmd_q[`CRMD_DAT_HI:`CRMD_DAT_LO] <= commit.wdata[`CRMD_DAT_HI:`CRMD_DAT_LO];
                    // da and pg must stay exclusive
                    if (commit.wdata[`CRMD_DA] ^ commit.wdata[`CRMD_PG])
                    begin
                        crmd_q[`CRMD_DA] <= commit.wdata[`CRMD_DA];
                        crmd_q[`CRMD_PG] <= commit.wdata[`CRMD_PG];
                    end
                end
                `CSR_ADDR_PRMD:   prmd_q <= commit.wdata[2:0];
                `CSR_ADDR_ECFG:   ecfg_lie <= {commit.wdata[12:11], 1'b0, commit.wdata[9:0]};
                `CSR_ADDR_ESTAT:  estat_is <= commit.wdata[1:0];  // only swi writable
                `CSR_ADDR_ERA:    era_q <= commit.wdata;
                `CSR_ADDR_BADV:   badv_q <= commit.wdata;
                `CSR_ADDR_EENTRY: eentry_q <= commit.wdata[`CSR_DATA_W-1:6];
                `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1, `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3:
                    save_q[commit.wnum[1:0]] <= commit.wdata;
                `CSR_ADDR_TID:    tid_q <= commit.wdata;
                default:
                    tid_q <= tid_q;
            endcase
        end
    end

endmodule

//--- verilog/csr_ctrl.sv
`timescale 1ns/100ps
`include "csr_config.svh"

module csr_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                cmd_valid,
    input  csr_pkg::csr_op_t    cmd_op,
    input  csr_pkg::csr_num_t   cmd_csr_num,
    input  csr_pkg::csr_data_t  cmd_wdata,
    input  csr_pkg::csr_data_t  cmd_mask,
    input  csr_pkg::csr_data_t  cmd_pc,
    input  csr_pkg::ecode_t     cmd_ecode,
    input  csr_pkg::esubcode_t  cmd_esubcode,
    input  csr_pkg::csr_data_t  cmd_badv,
    csr_commit_if.ctrl          commit,
    output csr_pkg::csr_data_t  rdata,
    output logic                redirect,
    output csr_pkg::csr_data_t  redirect_pc
);

    logic               take_int;
    logic               act;
    logic               is_access;  // rd, wr or xchg
    logic               is_write;
    logic               is_excp;
    logic               is_ertn;
    logic               redirect_d;
    csr_pkg::csr_data_t wmask;
    csr_pkg::csr_data_t target;
    csr_pkg::csr_data_t next_pc;

    assign take_int = commit.int_pending;      // interrupt wins over any command
    assign act      = cmd_valid && !take_int;
    assign next_pc  = cmd_pc + csr_pkg::csr_data_t'(`CSR_PC_STEP);

    always_comb
    begin
        is_access  = 1'b0;
        is_write   = 1'b0;
        is_excp    = take_int;
        is_ertn    = 1'b0;
        redirect_d = take_int;
        wmask      = cmd_mask;
        target     = commit.eentry;
        if (act)
        begin
            case (cmd_op)
                csr_pkg::OP_CSRRD:
                    is_access = 1'b1;
                csr_pkg::OP_CSRWR:
                begin
                    is_access  = 1'b1;
                    is_write   = 1'b1;
                    wmask      = '1;            // plain write
                    redirect_d = 1'b1;
                    target     = next_pc;
                end
                csr_pkg::OP_CSRXCHG:
                begin
                    is_access  = 1'b1;
                    is_write   = 1'b1;
                    redirect_d = 1'b1;
                    target     = next_pc;
                end
                csr_pkg::OP_ERTN:
                begin
                    is_ertn    = 1'b1;
                    redirect_d = 1'b1;
                    target     = commit.era;
                end
                csr_pkg::OP_EXCP:
                begin
                    is_excp    = 1'b1;
                    redirect_d = 1'b1;
                end
                default:
                    is_access = 1'b0;
            endcase
        end
    end

    assign commit.rnum       = cmd_csr_num;
    assign commit.we         = is_write;
    assign commit.wnum       = cmd_csr_num;
    assign commit.wdata      = (commit.rdata & ~wmask) | (cmd_wdata & wmask);
    assign commit.excp_enter = is_excp;
    assign commit.era_pc     = cmd_pc;
    assign commit.ecode      = take_int ? `ECODE_INT : cmd_ecode;
    assign commit.esubcode   = take_int ? '0 : cmd_esubcode;
    assign commit.badv_we    = is_excp && !take_int &&
                               (cmd_ecode == `ECODE_ADE || cmd_ecode == `ECODE_ALE);
    assign commit.badv       = cmd_badv;
    assign commit.ertn       = is_ertn;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rdata    <= '0;
            redirect <= 1'b0;
        end
        else
        begin
            redirect <= redirect_d;
            if (is_access)
                rdata <= commit.rdata;          // pre-write value
        end
    end

    always_ff @(posedge clk)
    begin
        if (redirect_d)
            redirect_pc <= target;
    end

endmodule

//--- verilog/csr_timer_if.sv
`timescale 1ns/100ps

interface csr_timer_if;

    logic               tcfg_we;
    csr_pkg::csr_data_t tcfg_wdata;
    logic               ticlr;      // write to ticlr with bit 0 set

    csr_pkg::csr_data_t tcfg;
    csr_pkg::csr_data_t tval;
    logic               ti;

    modport regfile (
        output tcfg_we, tcfg_wdata, ticlr,
        input  tcfg, tval, ti
    );

    modport timer (
        input  tcfg_we, tcfg_wdata, ticlr,
        output tcfg, tval, ti
    );

endinterface

//--- verilog/csr_commit_if.sv
`timescale 1ns/100ps

interface csr_commit_if;

    csr_pkg::csr_num_t  rnum;
    csr_pkg::csr_data_t rdata;      // combinational read of rnum

    logic               we;
    csr_pkg::csr_num_t  wnum;
    csr_pkg::csr_data_t wdata;      // already merged under mask

    logic               excp_enter;
    csr_pkg::csr_data_t era_pc;
    csr_pkg::ecode_t    ecode;
    csr_pkg::esubcode_t esubcode;
    logic               badv_we;
    csr_pkg::csr_data_t badv;
    logic               ertn;

    csr_pkg::csr_data_t era;
    csr_pkg::csr_data_t eentry;
    logic               int_pending;

    modport ctrl (
        output rnum, we, wnum, wdata, excp_enter, era_pc, ecode, esubcode, badv_we, badv, ertn,
        input  rdata, era, eentry, int_pending
    );

    modport regfile (
        input  rnum, we, wnum, wdata, excp_enter, era_pc, ecode, esubcode, badv_we, badv, ertn,
        output rdata, era, eentry, int_pending
    );

endinterface

//--- verilog/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_data_t;   // csr word or pc
    typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
    typedef logic [5:0]             ecode_t;
    typedef logic [8:0]             esubcode_t;

    // swi 1:0, hwi 9:2, bit 10 reserved, ti 11, ipi 12
    typedef logic [`CSR_HWI_N+4:0]  int_vec_t;

    typedef logic [`CSR_HWI_N-1:0]  hwi_t;
    typedef logic [8:0]             crmd_t;

    typedef enum logic [2:0] {
        OP_CSRRD   = 3'd0,
        OP_CSRWR   = 3'd1,
        OP_CSRXCHG = 3'd2,
        OP_ERTN    = 3'd3,
        OP_EXCP    = 3'd4
    } csr_op_t;

endpackage

//--- verilog/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define CSR_DATA_W      32
`define CSR_NUM_W       14
`define CSR_HWI_N       8
`define CSR_PC_STEP     4

`define CSR_ADDR_CRMD   14'h0
`define CSR_ADDR_PRMD   14'h1
`define CSR_ADDR_ECFG   14'h4
`define CSR_ADDR_ESTAT  14'h5
`define CSR_ADDR_ERA    14'h6
`define CSR_ADDR_BADV   14'h7
`define CSR_ADDR_EENTRY 14'hc
`define CSR_ADDR_SAVE0  14'h30
`define CSR_ADDR_SAVE1  14'h31
`define CSR_ADDR_SAVE2  14'h32
`define CSR_ADDR_SAVE3  14'h33
`define CSR_ADDR_TID    14'h40
`define CSR_ADDR_TCFG   14'h41
`define CSR_ADDR_TVAL   14'h42
`define CSR_ADDR_TICLR  14'h44

// ade and ale also load badv
`define ECODE_INT       6'h0
`define ECODE_ADE       6'h8
`define ECODE_ALE       6'h9

`define TCFG_EN         0
`define TCFG_PERIODIC   1
`define TCFG_INITV_HI   31
`define TCFG_INITV_LO   2

`define CRMD_PLV_HI     1
`define CRMD_PLV_LO     0
`define CRMD_IE         2
`define CRMD_DA         3
`define CRMD_PG         4
`define CRMD_DAT_HI     8
`define CRMD_DAT_LO     5

`endif
